/* design/elink_tx_consts.svh */
`ifndef ELINK_TX_CONSTS_SVH
`define ELINK_TX_CONSTS_SVH

// ---------------------------------------------------------------------------
// word FIFO sizing
// ---------------------------------------------------------------------------

// tagged 18-bit words held by the FIFO, power of two
`define ELINK_FIFO_DEPTH 16

// occupancy at which prog_full goes high
// leaves room for the words still in flight from the framer
`define ELINK_PROG_FULL_THRESH 12

// ---------------------------------------------------------------------------
// message framing
// ---------------------------------------------------------------------------

// longest message in words
// the word at this position always carries the end of message code
`define ELINK_MSG_MAX_WORDS 8

`endif

/* design/elink_tx_pkg.sv */
`default_nettype none

package elink_tx_pkg;

  // 2-bit word code, shared by FIFO words and line symbols
  typedef enum logic [1:0]
  {
    CODE_DATA  = 2'b00,  // middle of message
    CODE_EOM   = 2'b01,  // end of message
    CODE_SOM   = 2'b10,  // start of message
    CODE_COMMA = 2'b11   // idle / filler
  } elink_code_e;

  // tagged word as stored in the FIFO, 18 bits
  typedef struct packed
  {
    elink_code_e code;
    logic [15:0] payload;
  } elink_word_t;

  // one line symbol, 10 bits
  typedef struct packed
  {
    elink_code_e code;
    logic [7:0]  data;
  } elink_symbol_t;

  // framer: next word opens a message, or we are inside one
  typedef enum logic {FR_IDLE, FR_BODY} frame_state_e;

  // serializer: which half of the word goes out next
  typedef enum logic {PH_HIGH, PH_LOW} ser_phase_e;

endpackage

`default_nettype wire

/* design/elink_msg_framer.sv */
`timescale 1ns/10ps
`default_nettype none
`include "elink_tx_consts.svh"

module elink_msg_framer
  import elink_tx_pkg::*;
(
  input  wire              rd_clk,
  input  wire              rst,
  input  wire              fifo_flush,  // drops the in-flight word too
  input  wire       [15:0] msg_data,
  input  wire              msg_valid,   // one-cycle write strobe
  input  wire              msg_last,    // sampled with msg_valid
  input  wire              full,        // from the word FIFO
  output elink_word_t      wr_word,
  output logic             wr_en,
  output logic             overflow     // write cycle hit a full FIFO
);

  localparam int CNT_W = $clog2(`ELINK_MSG_MAX_WORDS);
  localparam logic [CNT_W-1:0] LAST_POS = CNT_W'(`ELINK_MSG_MAX_WORDS - 1);

  frame_state_e     state;
  logic [CNT_W-1:0] word_cnt;    // words accepted so far in this message
  logic             end_of_msg;
  elink_code_e      next_code;

  // -------------------------------------------------------------------------
  // tagging of the incoming word
  // -------------------------------------------------------------------------
  always_comb
  begin
    // forced end once the message reaches max length
    end_of_msg = msg_last || (word_cnt == LAST_POS);
    if (end_of_msg)
      next_code = CODE_EOM;   // beats SOM, one-word msg is a lone EOM
    else if (state == FR_IDLE)
      next_code = CODE_SOM;
    else
      next_code = CODE_DATA;
  end

  // -------------------------------------------------------------------------
  // state, word count and write strobe
  // -------------------------------------------------------------------------
  always_ff @(posedge rd_clk)
  begin
    if (rst || fifo_flush)
    begin
      state    <= FR_IDLE;
      word_cnt <= '0;
      wr_en    <= 1'b0;
    end
    else
    begin
      wr_en <= msg_valid;  // write lands one cycle after the strobe
      if (msg_valid)
      begin
        // count moves on even if the FIFO drops the word
        if (end_of_msg)
        begin
          state    <= FR_IDLE;
          word_cnt <= '0;
        end
        else
        begin
          state    <= FR_BODY;
          word_cnt <= word_cnt + 1'b1;
        end
      end
    end
  end

  // write register, one word in flight
  always_ff @(posedge rd_clk)
  begin
    if (msg_valid)
    begin
      wr_word.code    <= next_code;
      wr_word.payload <= msg_data;
    end
  end

  assign overflow = wr_en & full;  // word is lost this cycle

endmodule

`default_nettype wire

/* design/elink_word_fifo.sv */
`timescale 1ns/10ps
`default_nettype none
`include "elink_tx_consts.svh"

module elink_word_fifo
  import elink_tx_pkg::*;
#(
  parameter int DEPTH = `ELINK_FIFO_DEPTH  // power of two
)
(
  input  wire              rd_clk,
  input  wire              rst,
  input  wire              fifo_flush,
  input  wire elink_word_t wr_word,
  input  wire              wr_en,
  input  wire              pop,        // removes head at the edge
  output elink_word_t      rd_word,    // head word, valid when !empty
  output logic             full,
  output logic             empty,
  output logic             prog_full
);

  localparam int AW  = $clog2(DEPTH);
  localparam int CW  = AW + 1;
  localparam logic [AW:0] FULL_CNT = CW'(DEPTH);
  localparam logic [AW:0] PF_CNT   = CW'(`ELINK_PROG_FULL_THRESH);

  elink_word_t   mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;    // words stored
  logic          do_wr;
  logic          do_rd;
  logic          clr_q;    // rst or flush seen last cycle
  logic          out_en;   // prog_full enable

  assign full  = (count == FULL_CNT);
  assign empty = (count == '0);
  assign do_wr = wr_en & ~full;   // write while full is ignored
  assign do_rd = pop & ~empty;

  assign rd_word = mem[rd_ptr];   // fall-through head

  // -------------------------------------------------------------------------
  // pointers and occupancy
  // -------------------------------------------------------------------------
  always_ff @(posedge rd_clk)
  begin
    if (rst || fifo_flush)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is 2**AW
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  always_ff @(posedge rd_clk)
  begin
    if (do_wr)
      mem[wr_ptr] <= wr_word;
  end

  // prog_full mask, low during and one cycle past rst/flush
  always_ff @(posedge rd_clk)
  begin
    if (rst)
    begin
      clr_q  <= 1'b1;
      out_en <= 1'b0;
    end
    else
    begin
      clr_q  <= fifo_flush;
      out_en <= ~(fifo_flush | clr_q);
    end
  end

  assign prog_full = out_en & (count >= PF_CNT);

endmodule

`default_nettype wire

/* design/elink_byte_serializer.sv */
`timescale 1ns/10ps
`default_nettype none

module elink_byte_serializer
  import elink_tx_pkg::*;
(
  input  wire              rd_clk,
  input  wire              rst,
  input  wire              rd_en,     // one symbol per strobe
  input  wire elink_word_t rd_word,   // FIFO head
  input  wire              empty,
  output logic             pop,
  output elink_symbol_t    dout,
  output logic             dout_rdy   // rd_en delayed by one cycle
);

  localparam elink_symbol_t IDLE_SYM = '{code: CODE_COMMA, data: 8'h00};

  ser_phase_e  phase;
  elink_word_t held;   // word being sent
  logic        idle;   // high half went out as a comma

  // -------------------------------------------------------------------------
  // code of each half, from the word code
  // -------------------------------------------------------------------------

  // SOM marked on the low half, EOM on the high half
  function automatic elink_code_e high_code(input elink_code_e c);
    case (c)
      CODE_SOM:  high_code = CODE_COMMA;
      CODE_EOM:  high_code = CODE_EOM;
      CODE_DATA: high_code = CODE_DATA;
      default:   high_code = CODE_COMMA;  // never stored
    endcase
  endfunction

  function automatic elink_code_e low_code(input elink_code_e c);
    case (c)
      CODE_SOM:  low_code = CODE_SOM;
      CODE_EOM:  low_code = CODE_COMMA;
      CODE_DATA: low_code = CODE_DATA;
      default:   low_code = CODE_COMMA;
    endcase
  endfunction

  // take the head only at the start of a word
  assign pop = rd_en & (phase == PH_HIGH) & ~empty;

  // -------------------------------------------------------------------------
  // phase and output symbol
  // -------------------------------------------------------------------------
  always_ff @(posedge rd_clk)
  begin
    if (rst)
    begin
      phase    <= PH_HIGH;
      idle     <= 1'b1;
      dout_rdy <= 1'b0;
      dout     <= IDLE_SYM;
    end
    else
    begin
      dout_rdy <= rd_en;
      if (rd_en)
      begin
        if (phase == PH_HIGH)
        begin
          phase <= PH_LOW;
          idle  <= empty;        // nothing to send, pair of commas
          if (empty)
            dout <= IDLE_SYM;
          else
            dout <= '{code: high_code(rd_word.code), data: rd_word.payload[15:8]};
        end
        else
        begin
          phase <= PH_HIGH;
          if (idle)
            dout <= IDLE_SYM;
          else
            dout <= '{code: low_code(held.code), data: held.payload[7:0]};
        end
      end
    end
  end

  // latch the popped word for the low half
  always_ff @(posedge rd_clk)
  begin
    if (pop)
      held <= rd_word;
  end

endmodule

`default_nettype wire

/* design/elink_tx_top.sv */
`timescale 1ns/10ps
`default_nettype none

module elink_tx_top
  import elink_tx_pkg::*;
(
  input  wire                rd_clk,
  input  wire                rst,
  input  wire         [15:0] msg_data,
  input  wire                msg_valid,
  input  wire                msg_last,
  input  wire                rd_en,       // line side read strobe
  input  wire                fifo_flush,
  output wire elink_symbol_t dout,
  output wire                dout_rdy,
  output wire                empty,
  output wire                full,
  output wire                prog_full,
  output wire                overflow
);

  // ---------------------------------------------------------------------------
  // framer -> FIFO -> serializer
  // ---------------------------------------------------------------------------
  wire elink_word_t wr_word;   // tagged word to the FIFO
  wire              wr_en;
  wire elink_word_t rd_word;   // FIFO head
  wire              pop;

  elink_msg_framer u_framer (
    .rd_clk     (rd_clk),
    .rst        (rst),
    .fifo_flush (fifo_flush),
    .msg_data   (msg_data),
    .msg_valid  (msg_valid),
    .msg_last   (msg_last),
    .full       (full),
    .wr_word    (wr_word),
    .wr_en      (wr_en),
    .overflow   (overflow)
  );

  elink_word_fifo u_fifo (
    .rd_clk     (rd_clk),
    .rst        (rst),
    .fifo_flush (fifo_flush),
    .wr_word    (wr_word),
    .wr_en      (wr_en),
    .pop        (pop),
    .rd_word    (rd_word),
    .full       (full),
    .empty      (empty),
    .prog_full  (prog_full)
  );

  elink_byte_serializer u_ser (
    .rd_clk   (rd_clk),
    .rst      (rst),
    .rd_en    (rd_en),
    .rd_word  (rd_word),
    .empty    (empty),
    .pop      (pop),
    .dout     (dout),
    .dout_rdy (dout_rdy)
  );

endmodule

`default_nettype wire

/* test/elink_tx_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module elink_tx_chk
(
  input wire rd_clk,
  input wire rst,
  input wire rd_en,
  input wire dout_rdy,
  input wire pop,         // serializer to FIFO
  input wire empty,
  input wire full,
  input wire prog_full,
  input wire fifo_flush
);

  // --------------------------------------------------------------------------
  // FIFO side
  // --------------------------------------------------------------------------
  a_pop_empty: assert property (@(posedge rd_clk) disable iff (rst) !(pop && empty))
    else $error("pop raised while the FIFO is empty");

  a_full_empty: assert property (@(posedge rd_clk) disable iff (rst) !(full && empty))
    else $error("full and empty high together");

  // mask holds prog_full low right after a flush
  a_flush_pf: assert property (@(posedge rd_clk) disable iff (rst) fifo_flush |=> !prog_full)
    else $error("prog_full high in the cycle after fifo_flush");

  // --------------------------------------------------------------------------
  // line side, dout_rdy is rd_en one cycle late
  // --------------------------------------------------------------------------
  a_rdy_on: assert property (@(posedge rd_clk) disable iff (rst) rd_en |=> dout_rdy)
    else $error("dout_rdy missing one cycle after rd_en");

  a_rdy_off: assert property (@(posedge rd_clk) disable iff (rst) !rd_en |=> !dout_rdy)
    else $error("dout_rdy without an rd_en the cycle before");

endmodule

bind elink_tx_top elink_tx_chk u_chk (
  .rd_clk     (rd_clk),
  .rst        (rst),
  .rd_en      (rd_en),
  .dout_rdy   (dout_rdy),
  .pop        (pop),
  .empty      (empty),
  .full       (full),
  .prog_full  (prog_full),
  .fifo_flush (fifo_flush)
);

`default_nettype wire

/* test/elink_tx_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "elink_tx_consts.svh"

module elink_tx_tb
  import elink_tx_pkg::*;
;

  typedef enum logic [1:0] {T_MSG, T_IDLE, T_FILL, T_FLUSH} test_kind_e;

  typedef struct packed
  {
    test_kind_e kind;
    int         len;   // words, or read strobes for T_IDLE
    bit         last;  // last flag on the final word
  } test_t;

  localparam elink_symbol_t IDLE_SYM = '{code: CODE_COMMA, data: 8'h00};

  test_t tests [6] = '{
    '{T_MSG,   3,  1'b1},   // COMMA SOM DATA DATA EOM COMMA
    '{T_MSG,   1,  1'b1},   // lone EOM word
    '{T_MSG,   12, 1'b0},   // cut at max length, 8 + 4
    '{T_IDLE,  4,  1'b0},   // comma pairs only
    '{T_FILL,  18, 1'b0},   // two words dropped
    '{T_FLUSH, 16, 1'b0}    // flush a full FIFO
  };

  logic          rd_clk;
  logic          rst;
  logic [15:0]   msg_data;
  logic          msg_valid;
  logic          msg_last;
  logic          rd_en;
  logic          fifo_flush;
  elink_symbol_t dout;
  logic          dout_rdy;
  logic          empty;
  logic          full;
  logic          prog_full;
  logic          overflow;

  elink_symbol_t exp_q [$];    // symbols still due on the line
  int            seed    = 77;
  int            err_cnt = 0;
  int            n_checks = 0;
  int            ovf_cnt = 0;
  bit            m_body  = 1'b0;  // model framer, inside a message
  int            m_cnt   = 0;     // model framer, words so far

  elink_tx_top uut (
    .rd_clk     (rd_clk),
    .rst        (rst),
    .msg_data   (msg_data),
    .msg_valid  (msg_valid),
    .msg_last   (msg_last),
    .rd_en      (rd_en),
    .fifo_flush (fifo_flush),
    .dout       (dout),
    .dout_rdy   (dout_rdy),
    .empty      (empty),
    .full       (full),
    .prog_full  (prog_full),
    .overflow   (overflow)
  );

  initial
  begin
    rd_clk = 1'b0;
    forever #20 rd_clk = ~rd_clk;  // 40 ns
  end

  // --------------------------------------------------------------------------
  // reference model and checks
  // --------------------------------------------------------------------------
  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp)
    begin
      $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // code of the next word, EOM wins over SOM
  function automatic elink_code_e tag_word(input bit last);
    elink_code_e c;
    if (last || m_cnt == `ELINK_MSG_MAX_WORDS - 1)
    begin
      c      = CODE_EOM;
      m_body = 1'b0;
      m_cnt  = 0;
    end
    else
    begin
      c      = m_body ? CODE_DATA : CODE_SOM;
      m_body = 1'b1;
      m_cnt++;
    end
    return c;
  endfunction

  // SOM mark rides on the low half, EOM mark on the high half
  task automatic expect_word(input elink_word_t w);
    elink_symbol_t hi;
    elink_symbol_t lo;
    hi.data = w.payload[15:8];
    lo.data = w.payload[7:0];
    hi.code = (w.code == CODE_SOM) ? CODE_COMMA : w.code;
    lo.code = (w.code == CODE_EOM) ? CODE_COMMA : w.code;
    exp_q.push_back(hi);
    exp_q.push_back(lo);
  endtask

  // line side monitor, registered outputs settled by the falling edge
  always @(negedge rd_clk)
  begin
    if (!rst && dout_rdy)
    begin
      if (exp_q.size() == 0)
      begin
        $display("symbol at %0t arrived with nothing left to expect", $time);
        err_cnt++;
      end
      else
        check_val("dout", 32'(dout), 32'(exp_q.pop_front()));
    end
    if (!rst && overflow)
      ovf_cnt++;
  end

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  task automatic send_word(input bit last, input bit keep);
    elink_word_t w;
    w.payload = 16'($random(seed));
    w.code    = tag_word(last);
    @(posedge rd_clk);
    msg_data  <= w.payload;
    msg_valid <= 1'b1;
    msg_last  <= last;
    if (keep)
      expect_word(w);  // dropped words never reach the line
  endtask

  task automatic end_burst();
    @(posedge rd_clk);
    msg_valid <= 1'b0;
    msg_last  <= 1'b0;
    repeat (2) @(posedge rd_clk);  // framer register, then FIFO write
  endtask

  // strobe every second cycle, then wait for the monitor to drain
  task automatic read_syms(input int n);
    repeat (n)
    begin
      @(posedge rd_clk);
      rd_en <= 1'b1;
      @(posedge rd_clk);
      rd_en <= 1'b0;
    end
    while (exp_q.size() != 0)
      @(posedge rd_clk);
  endtask

  task automatic send_message(input int n, input bit last);
    for (int k = 0; k < n; k++)
      send_word(last && (k == n - 1), 1'b1);  // back to back
    end_burst();
    read_syms(2 * n);
  endtask

  task automatic idle_reads(input int n);
    repeat (n)
      exp_q.push_back(IDLE_SYM);
    read_syms(n);
    check_val("empty", 32'(empty), 1);
  endtask

  task automatic fill_overflow(input int n);
    int stored;
    int ovf0;
    ovf0 = ovf_cnt;
    for (int k = 0; k < n; k++)
    begin
      send_word(1'b0, k < `ELINK_FIFO_DEPTH);
      end_burst();
      @(negedge rd_clk);
      stored = (k < `ELINK_FIFO_DEPTH) ? k + 1 : `ELINK_FIFO_DEPTH;
      check_val("prog_full", 32'(prog_full), 32'(stored >= `ELINK_PROG_FULL_THRESH));
      check_val("full", 32'(full), 32'(stored == `ELINK_FIFO_DEPTH));
    end
    check_val("overflow_pulses", ovf_cnt - ovf0, n - `ELINK_FIFO_DEPTH);
    read_syms(2 * `ELINK_FIFO_DEPTH);
  endtask

  task automatic flush_midway(input int n);
    repeat (n)
      send_word(1'b0, 1'b0);   // flushed before any read
    end_burst();
    @(negedge rd_clk);
    check_val("full", 32'(full), 1);
    check_val("prog_full", 32'(prog_full), 1);
    @(posedge rd_clk);
    fifo_flush <= 1'b1;
    m_body = 1'b0;   // framer back to FR_IDLE
    m_cnt  = 0;
    @(posedge rd_clk);
    fifo_flush <= 1'b0;
    @(negedge rd_clk);
    check_val("prog_full", 32'(prog_full), 0);
    check_val("full", 32'(full), 0);
    check_val("empty", 32'(empty), 1);
    idle_reads(4);
    send_word(1'b0, 1'b1);   // must open with SOM again
    send_word(1'b1, 1'b1);
    end_burst();
    read_syms(4);
  endtask

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------
  initial
  begin : main
    int err0;
    rst        <= 1'b1;
    msg_data   <= '0;
    msg_valid  <= 1'b0;
    msg_last   <= 1'b0;
    rd_en      <= 1'b0;
    fifo_flush <= 1'b0;
    repeat (3) @(posedge rd_clk);
    rst <= 1'b0;
    @(negedge rd_clk);
    check_val("dout_rdy", 32'(dout_rdy), 0);
    check_val("prog_full", 32'(prog_full), 0);
    check_val("overflow", 32'(overflow), 0);
    check_val("dout", 32'(dout), 32'(IDLE_SYM));
    repeat (2) @(posedge rd_clk);   // prog_full mask clears
    foreach (tests[i])
    begin
      err0 = err_cnt;
      case (tests[i].kind)
        T_MSG:   send_message(tests[i].len, tests[i].last);
        T_IDLE:  idle_reads(tests[i].len);
        T_FILL:  fill_overflow(tests[i].len);
        default: flush_midway(tests[i].len);
      endcase
      $display("test %0d %s len %0d: %0d errors", i, tests[i].kind.name(), tests[i].len,
               err_cnt - err0);
    end
    $display("%0d tests, %0d checks, %0d errors", $size(tests), n_checks, err_cnt);
    if (err_cnt == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  // watchdog, 40 cycles per table word plus slack
  initial
  begin : watchdog
    int limit;
    int cycles;
    limit  = 200;
    cycles = 0;
    foreach (tests[i])
      limit += 40 * tests[i].len;
    while (cycles < limit)
    begin
      @(posedge rd_clk);
      cycles++;
    end
    $display("timeout after %0d cycles, expected symbols never arrived", limit);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+design
design/elink_tx_pkg.sv
design/elink_msg_framer.sv
design/elink_word_fifo.sv
design/elink_byte_serializer.sv
design/elink_tx_top.sv
test/elink_tx_chk.sv
test/elink_tx_tb.sv

/* Makefile */
SIM      = verilator
TOP      = elink_tx_tb
FILELIST = tb.f
FLAGS    = --binary --timing --assert
OBJ      = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ) $(LOG)
